//--- bfp_dot.f
design/bfp_pkg.sv
design/bfp_vector_mult.sv
design/bfp_skid_buffer.sv
design/bfp_block_reduce.sv
design/bfp_dot_product.sv
sim/tb_clock_gen.sv
sim/bfp_checker.sv
sim/tb_bfp_dot.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_bfp_dot -f bfp_dot.f
	@out="$$(./obj_dir/Vtb_bfp_dot)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- sim/bfp_golden.txt
# d0 d1 d2 d3 d4 d5 dexp w0 w1 w2 w3 w4 w5 wexp result_mantissa result_exponent
# hex fields; result = (sum of d*w) >>> 3 kept to 16 bits, exponent = dexp + wexp + 3
01 02 03 04 05 06 0a 01 01 01 01 01 01 14 0002 021
08 08 08 08 08 08 00 01 02 03 04 05 06 00 0015 003
ff ff ff ff ff ff 05 01 01 01 01 01 01 07 ffff 00f
10 10 10 10 10 10 01 10 10 10 10 10 10 02 00c0 006
0a 14 1e 28 32 3c 40 02 02 02 02 02 02 10 0034 053
f6 14 e2 28 ce 3c 80 03 03 03 03 03 03 01 000b 084
64 64 64 64 64 64 20 ff ff ff ff ff ff 20 ffb5 043
01 00 00 00 00 00 03 07 00 00 00 00 00 04 0000 00a
0c f4 0c f4 0c f4 11 05 05 05 05 05 05 22 0000 036
7f 7f 7f 7f 7f 7f 0a 7f 7f 7f 7f 7f 7f 0b 2f40 018
02 02 02 02 02 02 01 03 03 03 03 03 03 01 0004 005
04 04 04 04 04 04 02 04 04 04 04 04 04 02 000c 007
01 02 03 04 05 06 03 06 05 04 03 02 01 03 0007 009
fe fe fe fe fe fe 04 03 03 03 03 03 03 04 fffb 00b
20 20 20 20 20 20 05 20 20 20 20 20 20 05 0300 00d
e0 e0 e0 e0 e0 e0 06 20 20 20 20 20 20 06 fd00 00f
09 00 09 00 09 00 07 09 09 09 09 09 09 07 001e 011
00 00 00 00 00 32 08 00 00 00 00 00 32 08 0138 013
32 00 00 00 00 00 09 ce 00 00 00 00 00 09 fec7 015
01 01 01 01 01 01 10 01 01 01 01 01 01 10 0000 023
03 03 03 03 03 03 12 fd fd fd fd fd fd 13 fff9 028
40 40 40 40 40 40 30 02 02 02 02 02 02 00 0060 033
c0 c0 c0 c0 c0 c0 00 fe fe fe fe fe fe 30 0060 033
05 0a 0f 14 19 1e 50 01 01 01 01 01 01 05 000d 058
fb f6 f1 ec e7 e2 05 01 01 01 01 01 01 50 fff2 058
07 07 07 07 07 07 01 08 08 08 08 08 08 02 002a 006
0b 0b 0b 0b 0b 0b 02 01 01 01 01 01 01 03 0008 008
14 14 14 14 14 14 03 14 14 14 14 14 14 04 012c 00a
f9 f9 f9 f9 f9 f9 04 08 08 08 08 08 08 05 ffd6 00c
01 02 03 04 05 06 05 ff ff ff ff ff ff 06 fffd 00e
64 00 00 00 00 00 06 64 00 00 00 00 00 07 04e2 010
00 00 00 00 00 00 21 01 02 03 04 05 06 21 0000 045
0f 0f 0f 0f 0f 0f 44 0f 0f 0f 0f 0f 0f 11 00a8 058
80 80 80 80 80 80 ff 80 80 80 80 80 80 ff 3000 201
7f 7f 7f 7f 7f 7f ff 80 80 80 80 80 80 00 d060 102
00 00 00 00 00 00 00 00 00 00 00 00 00 ff 0000 102
7f 80 7f 80 7f 80 80 7f 7f 7f 7f 7f 7f 7f ffd0 102
80 80 80 80 80 80 ff 7f 7f 7f 7f 7f 7f ff d060 201
7f 7f 7f 7f 7f 7f fe 7f 7f 7f 7f 7f 7f 01 2f40 102
ff ff ff ff ff ff ff 80 80 80 80 80 80 ff 0060 201

//--- sim/tb_bfp_dot.sv
`timescale 1ns/1ps

module tb_bfp_dot;

  localparam int BLOCK_SIZE = 6;
  localparam int NUM_VECTORS = 40;

  logic clk;
  logic arst_n;
  bfp_pkg::man_t [BLOCK_SIZE-1:0] data_man;
  bfp_pkg::exp_t data_exp;
  logic data_valid;
  logic data_ready;
  bfp_pkg::man_t [BLOCK_SIZE-1:0] weight_man;
  bfp_pkg::exp_t weight_exp;
  logic weight_valid;
  logic weight_ready;
  bfp_pkg::bfp_result_t result;
  logic result_valid;
  logic result_ready;

  bfp_pkg::man_t [BLOCK_SIZE-1:0] data_mem [NUM_VECTORS];
  bfp_pkg::exp_t data_exp_mem [NUM_VECTORS];
  bfp_pkg::man_t [BLOCK_SIZE-1:0] weight_mem [NUM_VECTORS];
  bfp_pkg::exp_t weight_exp_mem [NUM_VECTORS];
  bfp_pkg::bfp_result_t golden_mem [NUM_VECTORS];
  int num_read = 0;
  integer seed = 32'hacdc;
  logic stall_output = 1'b0;

  tb_clock_gen #(.RESET_CYCLES(5)) tb_clock_gen_inst (.*);

  bfp_dot_product #(.BLOCK_SIZE(BLOCK_SIZE)) bfp_dot_product_inst (.*);

  bfp_checker bfp_checker_inst (.*);

  task automatic load_golden();
    int fd;
    string line;
    logic [15:0] f [16];
    fd = $fopen("sim/bfp_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/bfp_golden.txt for reading");
    end else begin
      while (!$feof(fd) && num_read < NUM_VECTORS) begin
        if ($fgets(line, fd) > 1 && line.substr(0, 0) != "#") begin
          if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13], f[14], f[15]) == 16) begin
            for (int i = 0; i < BLOCK_SIZE; i++) begin
              data_mem[num_read][i] = bfp_pkg::man_t'(f[i]);
              weight_mem[num_read][i] = bfp_pkg::man_t'(f[i+7]);
            end
            data_exp_mem[num_read] = bfp_pkg::exp_t'(f[6]);
            weight_exp_mem[num_read] = bfp_pkg::exp_t'(f[13]);
            golden_mem[num_read].mantissa = f[14];
            golden_mem[num_read].exponent = bfp_pkg::out_exp_t'(f[15]);
            num_read++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // drives one side of the input pair and holds each block until it is taken.
  task automatic send_stream(input bit weight_side, input int first, input int last,
                             input bit gaps);
    int idle;
    for (int v = first; v <= last; v++) begin
      idle = gaps ? ($random(seed) & 3) : 0;
      if (idle > 0) begin
        if (weight_side) begin
          weight_valid = 1'b0;
        end else begin
          data_valid = 1'b0;
        end
        repeat (idle) @(negedge clk);
      end
      if (weight_side) begin
        weight_man = weight_mem[v];
        weight_exp = weight_exp_mem[v];
        weight_valid = 1'b1;
      end else begin
        bfp_checker_inst.expect_result(golden_mem[v]);
        data_man = data_mem[v];
        data_exp = data_exp_mem[v];
        data_valid = 1'b1;
      end
      @(posedge clk);
      while (!(weight_side ? weight_ready : data_ready)) @(posedge clk);
      @(negedge clk);
    end
    if (weight_side) begin
      weight_valid = 1'b0;
    end else begin
      data_valid = 1'b0;
    end
  endtask

  task automatic run_phase(input int first, input int last, input bit gaps);
    fork
      send_stream(1'b0, first, last, gaps);
      send_stream(1'b1, first, last, gaps);
    join
  endtask

  initial begin
    result_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (stall_output) begin
        result_ready = ($random(seed) & 1) == 1;
      end else begin
        result_ready = 1'b1;
      end
    end
  end

  initial begin
    wait (num_read == NUM_VECTORS);
    repeat (num_read * 40 + 200) @(posedge clk);
    $display("timeout: only %0d of %0d results arrived", bfp_checker_inst.received, num_read);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    data_man = '0;
    data_exp = '0;
    data_valid = 1'b0;
    weight_man = '0;
    weight_exp = '0;
    weight_valid = 1'b0;
    load_golden();
    if (num_read != NUM_VECTORS) begin
      $display("golden file gave %0d vectors where %0d are needed", num_read, NUM_VECTORS);
      $display("TESTS FAILED");
      $finish;
    end else begin
      wait (arst_n === 1'b1);
      repeat (10) @(negedge clk); // nothing sent yet, so the output must stay quiet.
      run_phase(0, 9, 1'b0);
      while (bfp_checker_inst.received < 10) @(negedge clk);
      @(posedge clk);
      stall_output = 1'b1;
      @(negedge clk);
      run_phase(10, 24, 1'b0);
      while (bfp_checker_inst.received < 25) @(negedge clk);
      @(posedge clk);
      stall_output = 1'b0;
      @(negedge clk);
      run_phase(25, 32, 1'b1);
      run_phase(33, 39, 1'b0);
      while (bfp_checker_inst.received < num_read) @(negedge clk);
      repeat (20) @(negedge clk);
      $display("results received %0d of %0d, checks failed %0d",
               bfp_checker_inst.received, num_read, bfp_checker_inst.errors);
      if (bfp_checker_inst.errors == 0 && bfp_checker_inst.received == num_read) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- sim/bfp_checker.sv
`timescale 1ns/1ps

module bfp_checker (
  input logic clk,
  input logic arst_n,
  input logic data_valid,
  input logic data_ready,
  input logic weight_valid,
  input logic weight_ready,
  input bfp_pkg::bfp_result_t result,
  input logic result_valid,
  input logic result_ready
);

  bfp_pkg::bfp_result_t expected_q [$];
  bfp_pkg::bfp_result_t held;
  logic stalled = 1'b0;
  int received = 0;
  int errors = 0;

  // the driver queues each result in the order its block enters the DUT.
  task automatic expect_result(input bfp_pkg::bfp_result_t r);
    expected_q.push_back(r);
  endtask

  always @(posedge clk) begin
    bfp_pkg::bfp_result_t want;
    if (arst_n) begin
      // both inputs are taken together and only when both offer a block.
      if (data_ready !== weight_ready || (data_ready && !(data_valid && weight_valid))) begin
        errors++;
        $display("CHECK FAILED at %0t: readies data %b weight %b with valids data %b weight %b",
                 $time, data_ready, weight_ready, data_valid, weight_valid);
      end
      if (stalled && (!result_valid || result !== held)) begin
        errors++;
        $display("CHECK FAILED at %0t: result changed while stalled, held %h now %h",
                 $time, held, result);
      end
      if (result_valid && expected_q.size() == 0) begin
        errors++;
        $display("error at %0t: result_valid is high while no block is outstanding", $time);
      end else if (result_valid && result_ready) begin
        want = expected_q.pop_front();
        received++;
        if (result !== want) begin
          errors++;
          $display("CHECK FAILED at %0t: vector %0d got %h exp %h, expected %h exp %h",
                   $time, received, result.mantissa, result.exponent,
                   want.mantissa, want.exponent);
        end else begin
          $display("vector %0d: mantissa %h exponent %h ok",
                   received, result.mantissa, result.exponent);
        end
      end
      stalled = result_valid && !result_ready; // must look the same next edge.
      held = result;
    end
  end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // released away from the active edge.
  end

endmodule

//--- design/bfp_dot_product.sv
`timescale 1ns/1ps

module bfp_dot_product #(
  parameter int BLOCK_SIZE = 6
) (
  input logic clk,
  input logic arst_n,

  input bfp_pkg::man_t [BLOCK_SIZE-1:0] data_man,
  input bfp_pkg::exp_t data_exp,
  input logic data_valid,
  output logic data_ready,

  input bfp_pkg::man_t [BLOCK_SIZE-1:0] weight_man,
  input bfp_pkg::exp_t weight_exp,
  input logic weight_valid,
  output logic weight_ready,

  output bfp_pkg::bfp_result_t result,
  output logic result_valid,
  input logic result_ready
);

  bfp_pkg::prod_t [BLOCK_SIZE-1:0] prod_man;
  bfp_pkg::out_exp_t prod_exp;
  logic prod_valid;
  logic prod_ready;

  bfp_pkg::prod_t [BLOCK_SIZE-1:0] buf_man;
  bfp_pkg::out_exp_t buf_exp;
  logic buf_valid;
  logic buf_ready;

  bfp_vector_mult #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) bfp_vector_mult_inst (
    .clk(clk),
    .arst_n(arst_n),
    .data_man(data_man),
    .data_exp(data_exp),
    .data_valid(data_valid),
    .data_ready(data_ready),
    .weight_man(weight_man),
    .weight_exp(weight_exp),
    .weight_valid(weight_valid),
    .weight_ready(weight_ready),
    .prod_man(prod_man),
    .prod_exp(prod_exp),
    .prod_valid(prod_valid),
    .prod_ready(prod_ready)
  );

  // the buffer cuts the ready path between the tree and the multiplier.
  bfp_skid_buffer #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) bfp_skid_buffer_inst (
    .clk(clk),
    .arst_n(arst_n),
    .in_man(prod_man),
    .in_exp(prod_exp),
    .in_valid(prod_valid),
    .in_ready(prod_ready),
    .out_man(buf_man),
    .out_exp(buf_exp),
    .out_valid(buf_valid),
    .out_ready(buf_ready)
  );

  bfp_block_reduce #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) bfp_block_reduce_inst (
    .clk(clk),
    .arst_n(arst_n),
    .buf_man(buf_man),
    .buf_exp(buf_exp),
    .buf_valid(buf_valid),
    .buf_ready(buf_ready),
    .result(result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

endmodule

//--- design/bfp_block_reduce.sv
`timescale 1ns/1ps

module bfp_block_reduce #(
  parameter int BLOCK_SIZE = 6
) (
  input logic clk,
  input logic arst_n,

  input bfp_pkg::prod_t [BLOCK_SIZE-1:0] buf_man,
  input bfp_pkg::out_exp_t buf_exp,
  input logic buf_valid,
  output logic buf_ready,

  output bfp_pkg::bfp_result_t result,
  output logic result_valid,
  input logic result_ready
);

  localparam int LEVELS = $clog2(BLOCK_SIZE);
  localparam int SUM_WIDTH = bfp_pkg::PROD_WIDTH + LEVELS;

  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  sum_t leaf [BLOCK_SIZE];
  sum_t final_sum;
  sum_t shifted;
  logic advance;

  always_comb begin
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      leaf[i] = sum_t'($signed(buf_man[i])); // sign extend to the full sum width.
    end
  end

  // every stage moves together unless the last one is stuck.
  assign advance = !lvl[LEVELS].valid_q || result_ready;
  assign buf_ready = advance;

  for (genvar l = 1; l <= LEVELS; l++) begin : lvl
    localparam int N_IN = ((BLOCK_SIZE - 1) >> (l - 1)) + 1;
    localparam int N_OUT = (N_IN + 1) / 2;

    sum_t in_sum [N_IN];
    bfp_pkg::out_exp_t in_exp;
    logic in_valid;
    sum_t sum_d [N_OUT];
    sum_t sum_q [N_OUT];
    bfp_pkg::out_exp_t exp_q;
    logic valid_q;

    if (l == 1) begin : g_first
      assign in_sum = leaf;
      assign in_exp = buf_exp;
      assign in_valid = buf_valid;
    end else begin : g_next
      assign in_sum = lvl[l-1].sum_q;
      assign in_exp = lvl[l-1].exp_q;
      assign in_valid = lvl[l-1].valid_q;
    end

    for (genvar j = 0; j < N_OUT; j++) begin : node
      if (2 * j + 1 < N_IN) begin : g_pair
        assign sum_d[j] = in_sum[2*j] + in_sum[2*j+1];
      end else begin : g_odd
        assign sum_d[j] = in_sum[2*j]; // odd one out moves up unchanged.
      end
    end

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        valid_q <= 1'b0;
      end else if (advance) begin
        valid_q <= in_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (advance && in_valid) begin
        sum_q <= sum_d;
        exp_q <= in_exp;
      end
    end
  end

  assign final_sum = lvl[LEVELS].sum_q[0];

  // divide by the tree size and move that factor into the exponent.
  assign shifted = final_sum >>> LEVELS;
  assign result.mantissa = shifted[bfp_pkg::PROD_WIDTH-1:0];
  assign result.exponent = lvl[LEVELS].exp_q + bfp_pkg::out_exp_t'(LEVELS);
  assign result_valid = lvl[LEVELS].valid_q;

endmodule

//--- design/bfp_skid_buffer.sv
`timescale 1ns/1ps

module bfp_skid_buffer #(
  parameter int BLOCK_SIZE = 6
) (
  input logic clk,
  input logic arst_n,

  input bfp_pkg::prod_t [BLOCK_SIZE-1:0] in_man,
  input bfp_pkg::out_exp_t in_exp,
  input logic in_valid,
  output logic in_ready,

  output bfp_pkg::prod_t [BLOCK_SIZE-1:0] out_man,
  output bfp_pkg::out_exp_t out_exp,
  output logic out_valid,
  input logic out_ready
);

  bfp_pkg::prod_t [BLOCK_SIZE-1:0] skid_man;
  bfp_pkg::out_exp_t skid_exp;
  logic skid_valid;
  logic in_fire;
  logic main_free;

  // ready comes straight from a flop, so no path reaches back from the consumer.
  assign in_ready = !skid_valid;
  assign in_fire = in_valid && in_ready;
  assign main_free = out_ready || !out_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      out_valid <= skid_valid || in_fire; // skid drains first.
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        out_man <= skid_man;
        out_exp <= skid_exp;
      end else if (in_fire) begin
        out_man <= in_man;
        out_exp <= in_exp;
      end
    end else if (in_fire) begin
      // the main register is stalled, so the arriving item parks here.
      skid_man <= in_man;
      skid_exp <= in_exp;
    end
  end

endmodule

//--- design/bfp_vector_mult.sv
`timescale 1ns/1ps

module bfp_vector_mult #(
  parameter int BLOCK_SIZE = 6
) (
  input logic clk,
  input logic arst_n,

  input bfp_pkg::man_t [BLOCK_SIZE-1:0] data_man,
  input bfp_pkg::exp_t data_exp,
  input logic data_valid,
  output logic data_ready,

  input bfp_pkg::man_t [BLOCK_SIZE-1:0] weight_man,
  input bfp_pkg::exp_t weight_exp,
  input logic weight_valid,
  output logic weight_ready,

  output bfp_pkg::prod_t [BLOCK_SIZE-1:0] prod_man,
  output bfp_pkg::out_exp_t prod_exp,
  output logic prod_valid,
  input logic prod_ready
);

  logic reg_free;
  logic take;
  bfp_pkg::prod_t [BLOCK_SIZE-1:0] prod_d;
  bfp_pkg::out_exp_t exp_d;

  assign reg_free = !prod_valid || prod_ready; // register empty or being emptied.

  // both streams are taken together so blocks pair in arrival order.
  assign take = data_valid && weight_valid && reg_free;
  assign data_ready = take;
  assign weight_ready = take;

  always_comb begin
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      prod_d[i] = bfp_pkg::prod_t'($signed(data_man[i])) *
                  bfp_pkg::prod_t'($signed(weight_man[i]));
    end
  end

  assign exp_d = bfp_pkg::out_exp_t'(data_exp) + bfp_pkg::out_exp_t'(weight_exp);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_valid <= 1'b0;
    end else if (reg_free) begin
      prod_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      prod_man <= prod_d;
      prod_exp <= exp_d;
    end
  end

endmodule

//--- design/bfp_pkg.sv
package bfp_pkg;

  // input block widths.
  localparam int MAN_WIDTH = 8;
  localparam int EXP_WIDTH = 8;

  // a signed 8 by 8 product needs the full 16 bits only for -128 * -128.
  localparam int PROD_WIDTH = 2 * MAN_WIDTH;

  // exponent sum plus the normalizing shift fits in two extra bits.
  localparam int OUT_EXP_WIDTH = EXP_WIDTH + 2;

  typedef logic signed [MAN_WIDTH-1:0] man_t;
  typedef logic [EXP_WIDTH-1:0] exp_t;

  typedef logic signed [PROD_WIDTH-1:0] prod_t;
  typedef logic [OUT_EXP_WIDTH-1:0] out_exp_t;

  // one reduced block, as it leaves the design.
  typedef struct packed {
    prod_t mantissa;
    out_exp_t exponent;
  } bfp_result_t;

endpackage
